//--- compile.f
source/dcache_pkg.sv
source/dcache_array.sv
source/dcache_lookup.sv
source/dcache_ctrl.sv
source/dcache.sv
tb/clk_gen.sv
tb/dcache_tb.sv

//--- tb/dcache_tb.sv
// built for NUM_SETS 8 and 4 tags; halt is raised once at the end and the run stops after the flush
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();

    localparam int        NUM_SETS   = 8;
    localparam int        IDX_W      = $clog2(NUM_SETS);
    localparam int        N_TAGS     = 4;
    localparam int        N_OPS      = 400;
    localparam int        DIR_OPS    = 9;
    localparam int        CLK_PERIOD = 10;
    localparam int        DRIVE_DLY  = 1;
    localparam int        FLUSH_CYC  = NUM_SETS * 4 * 5 + 40;  // 4 words per set, up to 5 cycles each
    localparam int        LIMIT_CYC  = (N_OPS + DIR_OPS) * 40 + FLUSH_CYC + 20;
    localparam bit [31:0] SEED       = 32'ha39e_a555;

    logic  CLK;
    logic  nRST;
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_addr;
    word_t dmem_store;
    logic  halt;
    logic  dhit;
    word_t dmem_load;
    logic  flushed;
    logic  mem_ren;
    logic  mem_wen;
    word_t mem_addr;
    word_t mem_store;
    word_t mem_load;
    logic  mem_wait;

    word_t           mem_arr   [word_t];  // sparse memory contents
    word_t           ref_mem   [word_t];  // last stored value per word
    bit              blk_dirty [word_t];  // block stored to since its last write-back
    logic [WORD_W:0] xfer_log  [$];       // {write, addr} per completed transfer
    int unsigned     wait_tbl  [256];
    int unsigned     wait_pos;
    int unsigned     wait_left;
    bit              in_xfer;
    int              err_cnt;
    int              chk_cnt;

    clk_gen #(.HALF_PERIOD(CLK_PERIOD / 2), .RST_CYCLES(10)) clk_gen_i (.CLK(CLK), .nRST(nRST));

    dcache #(.NUM_SETS(NUM_SETS)) dcache_i (
        .CLK(CLK), .nRST(nRST),
        .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
        .dmem_store(dmem_store), .halt(halt),
        .dhit(dhit), .dmem_load(dmem_load), .flushed(flushed),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_store(mem_store),
        .mem_load(mem_load), .mem_wait(mem_wait)
    );

    function automatic word_t init_word(word_t a);
        return (a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;  // odd multiplier, every address bit counts
    endfunction

    function automatic word_t mem_read(word_t a);
        return mem_arr.exists(a) ? mem_arr[a] : init_word(a);
    endfunction

    function automatic word_t ref_value(word_t a);
        return ref_mem.exists(a) ? ref_mem[a] : init_word(a);
    endfunction

    function automatic bit is_dirty(word_t b);
        return blk_dirty.exists(b) && blk_dirty[b];
    endfunction

    function automatic word_t make_addr(int tag, int set, int word);
        return word_t'((tag << (IDX_W + 3)) | (set << 3) | (word << 2));
    endfunction

    task automatic report_mismatch(string name, word_t addr, word_t got, word_t exp);
        $display("ERROR %s addr %h got %h expected %h", name, addr, got, exp);
        err_cnt++;
    endtask

    task automatic report_fail(string what);
        $display("ERROR at %0t ns: %s", $time, what);
        err_cnt++;
    endtask

    task automatic take_write(word_t a, word_t d);
        word_t b;
        b = a & ~word_t'(7);
        chk_cnt++;
        if (!is_dirty(b)) begin
            report_fail($sformatf("memory write to block %h which holds no stored data", b));
        end
        if (d != ref_value(a)) begin
            report_mismatch("mem_store", a, d, ref_value(a));
        end
        mem_arr[a] = d;
        if (a[2]) begin
            blk_dirty[b] = 1'b0;  // second word ends the write-back
        end
        xfer_log.push_back({1'b1, a});
    endtask

    // memory side, one decision per cycle once the bus has settled
    always begin
        @(posedge CLK);
        #DRIVE_DLY;
        if (mem_ren && mem_wen) begin
            report_fail("mem_ren and mem_wen high in the same cycle");
        end
        if (mem_ren || mem_wen) begin
            if (!in_xfer) begin
                in_xfer   = 1'b1;
                wait_left = wait_tbl[wait_pos % 256];
                wait_pos++;
            end
            mem_load = mem_read(mem_addr);
            if (wait_left > 0) begin
                mem_wait = 1'b1;
                wait_left--;
            end else begin
                mem_wait = 1'b0;
                in_xfer  = 1'b0;
                if (mem_wen) begin
                    take_write(mem_addr, mem_store);
                end else begin
                    xfer_log.push_back({1'b0, mem_addr});
                end
            end
        end else begin
            mem_wait = 1'b0;
            in_xfer  = 1'b0;
        end
    end

    // one request held until dhit, then dropped one edge later
    task automatic access(input bit wr, input word_t addr, input word_t data, output int lat);
        word_t base;
        word_t wb;
        int    n;
        base = addr & ~word_t'(7);
        xfer_log.delete();
        dmem_ren   = !wr;
        dmem_wen   = wr;
        dmem_addr  = addr;
        dmem_store = data;
        lat        = 0;
        @(negedge CLK);
        while (!dhit) begin
            lat++;
            @(negedge CLK);
        end
        chk_cnt++;
        if (!wr && dmem_load != ref_value(addr)) begin
            report_mismatch("dmem_load", addr, dmem_load, ref_value(addr));
        end
        n = xfer_log.size();
        if (lat == 0 && n != 0) begin
            report_fail($sformatf("hit at %h caused memory traffic", addr));
        end else if (lat > 0 && n != 2 && n != 4) begin
            report_fail($sformatf("miss at %h made %0d memory transfers", addr, n));
        end else if (lat > 0) begin
            if (xfer_log[n-2] != {1'b0, base} || xfer_log[n-1] != {1'b0, base | word_t'(4)}) begin
                report_fail($sformatf("fill for %h did not read both words of its block", addr));
            end
            if (n == 4) begin
                wb = xfer_log[0][WORD_W-1:0];
                if (xfer_log[0] != {1'b1, wb[WORD_W-1:3], 3'b000}
                    || xfer_log[1] != {1'b1, wb | word_t'(4)}
                    || wb[IDX_W+2:3] != addr[IDX_W+2:3]) begin
                    report_fail($sformatf("write-back before the fill of %h is malformed", addr));
                end
            end
        end
        if (wr) begin
            ref_mem[addr]   = data;
            blk_dirty[base] = 1'b1;
        end
        @(posedge CLK);
        #DRIVE_DLY;
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
    endtask

    initial begin
        int    lat;
        int    i;
        bit    wr;
        word_t addr;
        void'($urandom(SEED));
        dmem_ren   = 1'b0;
        dmem_wen   = 1'b0;
        dmem_addr  = '0;
        dmem_store = '0;
        halt       = 1'b0;
        mem_wait   = 1'b0;
        mem_load   = '0;
        wait_pos   = 0;
        wait_left  = 0;
        in_xfer    = 1'b0;
        err_cnt    = 0;
        chk_cnt    = 0;
        for (i = 0; i < 256; i++) begin
            wait_tbl[i] = $urandom_range(3, 0);
        end
        wait (nRST === 1'b1);
        @(negedge CLK);
        if (dhit || flushed || mem_ren || mem_wen) begin
            report_fail("dhit, flushed, mem_ren or mem_wen high after reset");
        end
        @(posedge CLK);
        #DRIVE_DLY;

        // cold miss, then hits on the resident block
        access(1'b0, make_addr(0, 1, 0), '0, lat);
        if (lat == 0 || xfer_log.size() != 2) begin
            report_fail("first read of a block did not miss with exactly two reads");
        end
        access(1'b0, make_addr(0, 1, 0), '0, lat);
        if (lat != 0) report_fail("repeated read of a resident block missed");
        access(1'b1, make_addr(0, 1, 1), 32'hcafe_0001, lat);
        if (lat != 0) report_fail("write to a resident block missed");
        access(1'b0, make_addr(0, 1, 1), '0, lat);
        if (lat != 0) report_fail("read after write hit missed");

        // three tags into set 5, tag 1 is dirty and least recently used
        access(1'b0, make_addr(0, 5, 0), '0, lat);
        access(1'b1, make_addr(1, 5, 1), 32'h1234_5678, lat);
        access(1'b0, make_addr(0, 5, 1), '0, lat);
        access(1'b0, make_addr(2, 5, 0), '0, lat);
        if (xfer_log.size() != 4 || xfer_log[0] != {1'b1, make_addr(1, 5, 0)}
            || xfer_log[1] != {1'b1, make_addr(1, 5, 1)}) begin
            report_fail("eviction in set 5 did not write back the dirty LRU block first");
        end
        access(1'b0, make_addr(0, 5, 0), '0, lat);
        if (lat != 0) report_fail("recently used block in set 5 was evicted");

        for (i = 0; i < N_OPS; i++) begin
            wr   = 1'($urandom_range(1, 0));
            addr = make_addr($urandom_range(N_TAGS - 1, 0), $urandom_range(NUM_SETS - 1, 0),
                             $urandom_range(1, 0));
            access(wr, addr, $urandom, lat);
        end

        halt = 1'b1;
        @(negedge CLK);
        while (!flushed) begin
            @(negedge CLK);
        end
        for (i = 0; i < 16; i++) begin
            @(negedge CLK);
            if (!flushed) report_fail("flushed dropped after the flush finished");
        end
        for (i = 0; i < N_TAGS * NUM_SETS * 2; i++) begin
            addr = word_t'(i << 2);
            chk_cnt++;
            if (mem_read(addr) != ref_value(addr)) begin
                report_mismatch("mem", addr, mem_read(addr), ref_value(addr));
            end
        end

        $display("checks %0d errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(LIMIT_CYC * CLK_PERIOD);
        $display("ERROR watchdog expired after %0d cycles, a request or the flush never ended",
                 LIMIT_CYC);
        $display("checks %0d errors %0d", chk_cnt, err_cnt + 1);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/clk_gen.sv
// free-running clock from time 0; nRST is released 1 ns after the last reset edge
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int HALF_PERIOD = 5,
    parameter int RST_CYCLES  = 10
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (RST_CYCLES) @(posedge CLK);
        #1 nRST = 1'b1;  // released clear of the edge
    end

endmodule

`default_nettype wire

//--- source/dcache.sv
// NUM_SETS must be a power of two >= 2; address bits [1:0] are ignored, one private memory bus
`timescale 1ns/1ps
`default_nettype none

module dcache
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 8,
    localparam int IDX_W = $clog2(NUM_SETS),
    localparam int TAG_W = WORD_W - IDX_W - WSEL_W - BYTE_OFF_W
) (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  dmem_ren,
    input  logic  dmem_wen,
    input  word_t dmem_addr,
    input  word_t dmem_store,
    input  logic  halt,
    output logic  dhit,
    output word_t dmem_load,
    output logic  flushed,
    output logic  mem_ren,
    output logic  mem_wen,
    output word_t mem_addr,
    output word_t mem_store,
    input  word_t mem_load,
    input  logic  mem_wait
);

    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] req_idx;
    word_sel_t        req_word;
    logic [IDX_W-1:0] rd_idx;
    logic             idle;
    way_t             hit_way;
    way_t             lru_victim;
    logic [TAG_W-1:0] tag0;
    logic [TAG_W-1:0] tag1;
    logic             valid0;
    logic             valid1;
    logic             dirty0;
    logic             dirty1;
    word_t            data0_w0;
    word_t            data0_w1;
    word_t            data1_w0;
    word_t            data1_w1;
    logic             wr_en;
    way_t             wr_way;
    word_sel_t        wr_word;
    word_t            wr_data;
    logic             tag_wr;
    logic [TAG_W-1:0] tag_in;
    logic             set_valid;
    logic             clr_valid;
    logic             set_dirty;
    logic             clr_dirty;
    logic             lru_wr;
    way_t             lru_way;

    // tag | index | word | byte offset
    assign req_tag  = dmem_addr[WORD_W-1 -: TAG_W];
    assign req_idx  = dmem_addr[BYTE_OFF_W+WSEL_W +: IDX_W];
    assign req_word = dmem_addr[BYTE_OFF_W +: WSEL_W];

    dcache_array #(.NUM_SETS(NUM_SETS)) array_i (
        .CLK(CLK), .nRST(nRST), .rd_idx(rd_idx),
        .wr_en(wr_en), .wr_way(wr_way), .wr_word(wr_word), .wr_data(wr_data),
        .tag_wr(tag_wr), .tag_in(tag_in),
        .set_valid(set_valid), .clr_valid(clr_valid),
        .set_dirty(set_dirty), .clr_dirty(clr_dirty),
        .lru_wr(lru_wr), .lru_way(lru_way),
        .tag0(tag0), .tag1(tag1), .valid0(valid0), .valid1(valid1),
        .dirty0(dirty0), .dirty1(dirty1),
        .data0_w0(data0_w0), .data0_w1(data0_w1),
        .data1_w0(data1_w0), .data1_w1(data1_w1),
        .lru_victim(lru_victim)
    );

    dcache_lookup #(.NUM_SETS(NUM_SETS)) lookup_i (
        .req_tag(req_tag), .req_word(req_word),
        .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .idle(idle),
        .tag0(tag0), .tag1(tag1), .valid0(valid0), .valid1(valid1),
        .data0_w0(data0_w0), .data0_w1(data0_w1),
        .data1_w0(data1_w0), .data1_w1(data1_w1),
        .dhit(dhit), .hit_way(hit_way), .dmem_load(dmem_load)
    );

    dcache_ctrl #(.NUM_SETS(NUM_SETS)) ctrl_i (
        .CLK(CLK), .nRST(nRST),
        .dmem_wen(dmem_wen), .dmem_ren(dmem_ren), .dmem_store(dmem_store),
        .req_tag(req_tag), .req_idx(req_idx), .req_word(req_word), .halt(halt),
        .dhit(dhit), .hit_way(hit_way), .lru_victim(lru_victim),
        .tag0(tag0), .tag1(tag1), .valid0(valid0), .valid1(valid1),
        .dirty0(dirty0), .dirty1(dirty1),
        .data0_w0(data0_w0), .data0_w1(data0_w1),
        .data1_w0(data1_w0), .data1_w1(data1_w1),
        .mem_wait(mem_wait), .mem_load(mem_load),
        .idle(idle), .flushed(flushed), .rd_idx(rd_idx),
        .wr_en(wr_en), .wr_way(wr_way), .wr_word(wr_word), .wr_data(wr_data),
        .tag_wr(tag_wr), .tag_in(tag_in),
        .set_valid(set_valid), .clr_valid(clr_valid),
        .set_dirty(set_dirty), .clr_dirty(clr_dirty),
        .lru_wr(lru_wr), .lru_way(lru_way),
        .mem_ren(mem_ren), .mem_wen(mem_wen),
        .mem_addr(mem_addr), .mem_store(mem_store)
    );

endmodule

`default_nettype wire

//--- source/dcache_ctrl.sv
// requests must hold stable until dhit; halt must stay high once raised and is honoured only when idle
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 8,
    localparam int IDX_W = $clog2(NUM_SETS),
    localparam int TAG_W = WORD_W - IDX_W - WSEL_W - BYTE_OFF_W
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             dmem_wen,
    input  logic             dmem_ren,
    input  word_t            dmem_store,
    input  logic [TAG_W-1:0] req_tag,
    input  logic [IDX_W-1:0] req_idx,
    input  word_sel_t        req_word,
    input  logic             halt,
    input  logic             dhit,
    input  way_t             hit_way,
    input  way_t             lru_victim,
    input  logic [TAG_W-1:0] tag0,
    input  logic [TAG_W-1:0] tag1,
    input  logic             valid0,
    input  logic             valid1,
    input  logic             dirty0,
    input  logic             dirty1,
    input  word_t            data0_w0,
    input  word_t            data0_w1,
    input  word_t            data1_w0,
    input  word_t            data1_w1,
    input  logic             mem_wait,
    input  word_t            mem_load,
    output logic             idle,
    output logic             flushed,
    output logic [IDX_W-1:0] rd_idx,
    output logic             wr_en,
    output way_t             wr_way,
    output word_sel_t        wr_word,
    output word_t            wr_data,
    output logic             tag_wr,
    output logic [TAG_W-1:0] tag_in,
    output logic             set_valid,
    output logic             clr_valid,
    output logic             set_dirty,
    output logic             clr_dirty,
    output logic             lru_wr,
    output way_t             lru_way,
    output logic             mem_ren,
    output logic             mem_wen,
    output word_t            mem_addr,
    output word_t            mem_store
);

    ctrl_state_t      state;
    ctrl_state_t      next_state;
    logic [IDX_W-1:0] flush_idx;
    logic             idx_inc;
    logic             flushing;
    logic             last_set;
    logic             xfer_done;
    way_t             sel_way;    // victim on a miss, fixed way during flush
    logic [TAG_W-1:0] sel_tag;
    logic             sel_wb;
    word_t            sel_w0;
    word_t            sel_w1;

    function automatic word_t blk_addr(
        input logic [TAG_W-1:0] tag,
        input logic [IDX_W-1:0] idx,
        input word_sel_t        word
    );
        blk_addr = {tag, idx, word, {BYTE_OFF_W{1'b0}}};
    endfunction

    assign flushing  = state inside {FLUSH_A_W0, FLUSH_A_W1, FLUSH_B_W0, FLUSH_B_W1};
    assign idle      = (state == IDLE);
    assign flushed   = (state == DONE);
    assign rd_idx    = flushing ? flush_idx : req_idx;
    assign last_set  = (flush_idx == IDX_W'(NUM_SETS - 1));
    assign xfer_done = !mem_wait;

    always_comb begin
        case (state)
            FLUSH_A_W0, FLUSH_A_W1: sel_way = 1'b0;
            FLUSH_B_W0, FLUSH_B_W1: sel_way = 1'b1;
            default:                sel_way = lru_victim;
        endcase
    end

    assign sel_tag = sel_way ? tag1 : tag0;
    assign sel_wb  = sel_way ? (valid1 && dirty1) : (valid0 && dirty0);  // only valid dirty blocks
    assign sel_w0  = sel_way ? data1_w0 : data0_w0;
    assign sel_w1  = sel_way ? data1_w1 : data0_w1;
    assign tag_in  = req_tag;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_idx <= '0;
        end else begin
            state <= next_state;
            if (idx_inc) begin
                flush_idx <= flush_idx + 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        idx_inc    = 1'b0;
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        mem_addr   = '0;
        mem_store  = '0;
        wr_en      = 1'b0;
        wr_way     = sel_way;
        wr_word    = '0;
        wr_data    = mem_load;
        tag_wr     = 1'b0;
        set_valid  = 1'b0;
        clr_valid  = 1'b0;
        set_dirty  = 1'b0;
        clr_dirty  = 1'b0;
        lru_wr     = 1'b0;
        lru_way    = ~hit_way;  // the other way becomes least recently used
        case (state)
            IDLE: begin
                wr_way  = hit_way;
                wr_word = req_word;
                wr_data = dmem_store;
                if (dhit) begin
                    lru_wr = 1'b1;
                    if (dmem_wen) begin
                        wr_en     = 1'b1;
                        set_dirty = 1'b1;
                    end
                end else if (dmem_ren || dmem_wen) begin
                    next_state = sel_wb ? WB_W0 : FILL_W0;
                end else if (halt) begin
                    next_state = FLUSH_A_W0;
                end
            end
            WB_W0: begin
                mem_wen   = 1'b1;
                mem_addr  = blk_addr(sel_tag, rd_idx, word_sel_t'(0));
                mem_store = sel_w0;
                if (xfer_done) begin
                    next_state = WB_W1;
                end
            end
            WB_W1: begin
                mem_wen   = 1'b1;
                mem_addr  = blk_addr(sel_tag, rd_idx, word_sel_t'(1));
                mem_store = sel_w1;
                if (xfer_done) begin
                    clr_dirty  = 1'b1;
                    next_state = FILL_W0;
                end
            end
            FILL_W0: begin
                mem_ren  = 1'b1;
                mem_addr = blk_addr(req_tag, req_idx, word_sel_t'(0));
                wr_word  = word_sel_t'(0);
                if (xfer_done) begin
                    wr_en      = 1'b1;
                    next_state = FILL_W1;
                end
            end
            FILL_W1: begin
                mem_ren  = 1'b1;
                mem_addr = blk_addr(req_tag, req_idx, word_sel_t'(1));
                wr_word  = word_sel_t'(1);
                if (xfer_done) begin
                    wr_en      = 1'b1;
                    tag_wr     = 1'b1;
                    set_valid  = 1'b1;
                    next_state = IDLE;  // request hits on return
                end
            end
            FLUSH_A_W0, FLUSH_B_W0: begin
                mem_wen   = sel_wb;
                mem_addr  = blk_addr(sel_tag, rd_idx, word_sel_t'(0));
                mem_store = sel_w0;
                if (xfer_done || !sel_wb) begin
                    next_state = (state == FLUSH_A_W0) ? FLUSH_A_W1 : FLUSH_B_W1;
                end
            end
            FLUSH_A_W1, FLUSH_B_W1: begin
                mem_wen   = sel_wb;
                mem_addr  = blk_addr(sel_tag, rd_idx, word_sel_t'(1));
                mem_store = sel_w1;
                if (xfer_done || !sel_wb) begin
                    clr_valid = 1'b1;
                    clr_dirty = 1'b1;
                    if (state == FLUSH_A_W1) begin
                        next_state = FLUSH_B_W0;
                    end else if (last_set) begin
                        next_state = DONE;
                    end else begin
                        idx_inc    = 1'b1;
                        next_state = FLUSH_A_W0;
                    end
                end
            end
            DONE: begin
                next_state = DONE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    mem_dir_excl: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen)
    );

    // back-pressure holds the transfer until the memory accepts it
    mem_hold: assert property (
        @(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_wait |=> $stable(mem_addr) && $stable(mem_store)
    );

endmodule

`default_nettype wire

//--- source/dcache_lookup.sv
// purely combinational; dhit is only meaningful while the controller is idle
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 8,
    localparam int IDX_W = $clog2(NUM_SETS),
    localparam int TAG_W = WORD_W - IDX_W - WSEL_W - BYTE_OFF_W
) (
    input  logic [TAG_W-1:0] req_tag,
    input  word_sel_t        req_word,
    input  logic             dmem_ren,
    input  logic             dmem_wen,
    input  logic             idle,
    input  logic [TAG_W-1:0] tag0,
    input  logic [TAG_W-1:0] tag1,
    input  logic             valid0,
    input  logic             valid1,
    input  word_t            data0_w0,
    input  word_t            data0_w1,
    input  word_t            data1_w0,
    input  word_t            data1_w1,
    output logic             dhit,
    output way_t             hit_way,
    output word_t            dmem_load
);

    logic hit0;
    logic hit1;
    logic req;
    word_t way0_word;
    word_t way1_word;

    // a way only matches with its valid bit set
    assign hit0 = valid0 && (tag0 == req_tag);
    assign hit1 = valid1 && (tag1 == req_tag);
    assign req  = dmem_ren || dmem_wen;

    assign hit_way = hit1;  // way 0 unless way 1 matched
    assign dhit    = idle && req && (hit0 || hit1);

    assign way0_word = (req_word == word_sel_t'(1)) ? data0_w1 : data0_w0;
    assign way1_word = (req_word == word_sel_t'(1)) ? data1_w1 : data1_w0;

    always_comb begin
        if (hit_way) begin
            dmem_load = way1_word;
        end else begin
            dmem_load = way0_word;
        end
    end

    // a fill only ever targets the LRU way after a miss, so one set never holds a tag twice
    always_comb begin
        no_dup_tag: assert final (!(valid0 && valid1 && (tag0 == tag1)));
    end

endmodule

`default_nettype wire

//--- source/dcache_array.sv
// NUM_SETS must be a power of two >= 2; reads are asynchronous, so storage maps to flops or LUT RAM
`timescale 1ns/1ps
`default_nettype none

module dcache_array
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 8,
    localparam int IDX_W = $clog2(NUM_SETS),
    localparam int TAG_W = WORD_W - IDX_W - WSEL_W - BYTE_OFF_W
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic [IDX_W-1:0] rd_idx,     // read index, also the write index
    input  logic             wr_en,
    input  way_t             wr_way,
    input  word_sel_t        wr_word,
    input  word_t            wr_data,
    input  logic             tag_wr,
    input  logic [TAG_W-1:0] tag_in,
    input  logic             set_valid,
    input  logic             clr_valid,
    input  logic             set_dirty,
    input  logic             clr_dirty,
    input  logic             lru_wr,
    input  way_t             lru_way,    // way that becomes the next victim
    output logic [TAG_W-1:0] tag0,
    output logic [TAG_W-1:0] tag1,
    output logic             valid0,
    output logic             valid1,
    output logic             dirty0,
    output logic             dirty1,
    output word_t            data0_w0,
    output word_t            data0_w1,
    output word_t            data1_w0,
    output word_t            data1_w1,
    output way_t             lru_victim
);

    word_t               data_q  [2][NUM_SETS][BLK_WORDS];
    logic [TAG_W-1:0]    tag_q   [2][NUM_SETS];
    logic [NUM_SETS-1:0] valid_q [2];
    logic [NUM_SETS-1:0] dirty_q [2];
    logic [NUM_SETS-1:0] lru_q;  // one bit per set, names the LRU way

    // payload storage
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            data_q[wr_way][rd_idx][wr_word] <= wr_data;
        end
        if (tag_wr) begin
            tag_q[wr_way][rd_idx] <= tag_in;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
            lru_q      <= '0;  // way 0 is the first victim
        end else begin
            if (set_valid) begin
                valid_q[wr_way][rd_idx] <= 1'b1;
            end else if (clr_valid) begin
                valid_q[wr_way][rd_idx] <= 1'b0;
            end
            if (set_dirty) begin
                dirty_q[wr_way][rd_idx] <= 1'b1;
            end else if (clr_dirty) begin
                dirty_q[wr_way][rd_idx] <= 1'b0;
            end
            if (lru_wr) begin
                lru_q[rd_idx] <= lru_way;
            end
        end
    end

    assign tag0       = tag_q[0][rd_idx];
    assign tag1       = tag_q[1][rd_idx];
    assign valid0     = valid_q[0][rd_idx];
    assign valid1     = valid_q[1][rd_idx];
    assign dirty0     = dirty_q[0][rd_idx];
    assign dirty1     = dirty_q[1][rd_idx];
    assign data0_w0   = data_q[0][rd_idx][0];
    assign data0_w1   = data_q[0][rd_idx][1];
    assign data1_w0   = data_q[1][rd_idx][0];
    assign data1_w1   = data_q[1][rd_idx][1];
    assign lru_victim = lru_q[rd_idx];

    // fill sets valid, flush clears it; the controller never asks for both
    valid_cmd_excl: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(set_valid && clr_valid)
    );

endmodule

`default_nettype wire

//--- source/dcache_pkg.sv
// the datapath is built for exactly two words per block and two ways; only NUM_SETS is free
`default_nettype none

package dcache_pkg;

    parameter int WORD_W     = 32;  // data word and byte address
    parameter int BYTE_OFF_W = 2;   // ignored, all accesses are whole words
    parameter int BLK_WORDS  = 2;
    parameter int WSEL_W     = $clog2(BLK_WORDS);

    // one data word or one byte address
    typedef logic [WORD_W-1:0] word_t;

    // word within a block
    typedef logic [WSEL_W-1:0] word_sel_t;

    // way within a set, 0 or 1
    typedef logic way_t;

    typedef enum logic [3:0] {
        IDLE,        // hits served here, misses and halt detected
        WB_W0,       // write back dirty victim, first word
        WB_W1,
        FILL_W0,     // read requested block into the victim way
        FILL_W1,
        FLUSH_A_W0,  // flush way 0 of the current set
        FLUSH_A_W1,
        FLUSH_B_W0,  // flush way 1 of the current set
        FLUSH_B_W1,
        DONE         // all sets flushed, held until reset
    } ctrl_state_t;

endpackage

`default_nettype wire
